// File: bench/front_panel_tb.sv
`timescale 1ns/1ps

module front_panel_tb;

    logic        clk_5MHz;
    logic        n_rst;
    logic [31:0] hex_value;
    logic [7:0]  dp;
    logic [7:0]  leds_green;
    logic [7:0]  leds_red;
    logic        display_off;
    logic [2:0]  display_level;
    logic [7:0]  keys;
    logic        tm1638_strobe;
    logic        tm1638_clk;
    wire         tm1638_data_io;

    logic [31:0] key_pattern;
    logic [7:0]  model_ram [16];
    logic [7:0]  model_ctrl;
    int          model_data_count;
    integer      seed;
    int          wait_limit;

    pullup (tm1638_data_io);

    always #100 clk_5MHz = ~clk_5MHz;

    front_panel_top u_dut
    (
        .clk_5MHz       (clk_5MHz),
        .n_rst          (n_rst),
        .hex_value      (hex_value),
        .dp             (dp),
        .leds_green     (leds_green),
        .leds_red       (leds_red),
        .display_off    (display_off),
        .display_level  (display_level),
        .keys           (keys),
        .tm1638_strobe  (tm1638_strobe),
        .tm1638_clk     (tm1638_clk),
        .tm1638_data_io (tm1638_data_io)
    );

    tm1638_board_model u_board
    (
        .strobe      (tm1638_strobe),
        .sclk        (tm1638_clk),
        .dio         (tm1638_data_io),
        .key_pattern (key_pattern),
        .ram         (model_ram),
        .ctrl_byte   (model_ctrl),
        .data_count  (model_data_count)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected)
        else
        begin
            report_failure($sformatf("ERR time=%0t %s expected=%h actual=%h",
                                     $time, name, expected, actual));
        end
    endtask

    // gfedcba pattern of one hex digit
    function automatic logic [6:0] segments_for(input logic [3:0] nib);
        logic [6:0] table_seg [16];
        table_seg = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                      7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return table_seg[nib];
    endfunction

    task automatic wait_strobe_rise();
        int   cycles;
        logic prev;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        prev   = tm1638_strobe;
        while (!seen && cycles < wait_limit)
        begin
            @(negedge clk_5MHz);
            cycles++;
            seen = !prev && tm1638_strobe;
            prev = tm1638_strobe;
        end
        if (!seen)
            report_failure("tm1638_strobe did not rise before the timeout");
    endtask

    // four command groups make up a frame
    task automatic wait_frame_end();
        repeat (4) wait_strobe_rise();
    endtask

    task automatic randomize_inputs();
        logic [31:0] r;
        hex_value     = $random(seed);
        r             = $random(seed);
        dp            = r[7:0];
        leds_green    = r[15:8];
        leds_red      = r[23:16];
        display_off   = r[24];
        display_level = r[27:25];
        key_pattern   = $random(seed);
    endtask

    task automatic check_frame();
        logic [7:0] exp_keys;
        logic [7:0] key_byte;
        logic [3:0] nib;
        check_value("u_board.data_count", 8'd16, 8'(model_data_count));
        for (int n = 0; n < tm1638_pkg::NUM_DIGITS; n++)
        begin
            nib = 4'(hex_value >> (28 - 4 * n));    // leftmost digit first
            check_value($sformatf("u_board.ram[%0d]", 2 * n),
                        {dp[3'(7 - n)], segments_for(nib)}, model_ram[4'(2 * n)]);
            check_value($sformatf("u_board.ram[%0d]", 2 * n + 1),
                        {6'b0, leds_red[3'(7 - n)], leds_green[3'(7 - n)]},
                        model_ram[4'(2 * n + 1)]);
        end
        check_value("u_board.ctrl_byte", {4'h8, ~display_off, display_level}, model_ctrl);
        exp_keys = 8'h00;
        for (int k = 0; k < tm1638_pkg::KEY_BYTES; k++)
        begin
            key_byte              = 8'(key_pattern >> (8 * k));
            exp_keys[3'(7 - k)]   = key_byte[0];
            exp_keys[3'(3 - k)]   = key_byte[4];
        end
        check_value("keys", exp_keys, keys);
    endtask

    initial
    begin
        seed          = 32'hc0f0;
        wait_limit    = 4000;
        clk_5MHz      = 1'b0;
        n_rst         = 1'b1;
        hex_value     = 32'h0123_4567;
        dp            = 8'hA5;
        leds_green    = 8'h0F;
        leds_red      = 8'h3C;
        display_off   = 1'b0;
        display_level = 3'd7;
        key_pattern   = 32'h1122_8811;
        repeat (3) @(negedge clk_5MHz);
        check_value("tm1638_strobe", 8'h01, {7'b0, tm1638_strobe});
        check_value("tm1638_clk", 8'h01, {7'b0, tm1638_clk});
        check_value("keys", 8'h00, keys);
        n_rst = 1'b0;
        wait_frame_end();
        check_frame();
        // remaining digits with the display switched off
        hex_value     = 32'h89AB_CDEF;
        dp            = 8'h5A;
        display_off   = 1'b1;
        display_level = 3'd2;
        key_pattern   = 32'hEE77_0F10;
        wait_frame_end();
        check_frame();
        for (int f = 0; f < 20; f++)
        begin
            randomize_inputs();
            wait_frame_end();
            check_frame();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: bench/tm1638_board_model.sv
`timescale 1ns/1ps

module tm1638_board_model
(
    input  logic        strobe,
    input  logic        sclk,
    inout  wire         dio,
    input  logic [31:0] key_pattern,    // key byte k in bits 8k+7..8k
    output logic [7:0]  ram [16],
    output logic [7:0]  ctrl_byte,
    output int          data_count      // data bytes of the last address group
);

    logic [7:0]  shift;
    logic [31:0] keys_left;
    logic [3:0]  addr;
    logic        addr_group;
    logic        drive_en;
    logic        drive_bit;
    int          bit_cnt;
    int          byte_cnt;

    assign dio = drive_en ? drive_bit : 1'bz;

    // key bits change on the falling bus clock, lsb of byte 0 first
    task automatic serve_keys();
        keys_left = key_pattern;
        for (int i = 0; i < tm1638_pkg::BYTE_BITS * tm1638_pkg::KEY_BYTES; i++)
        begin
            @(negedge sclk or posedge strobe);
            if (strobe)
                return;
            drive_en  = 1'b1;
            drive_bit = keys_left[0];
            keys_left = keys_left >> 1;
            @(posedge sclk or posedge strobe);
            if (strobe)
                return;
        end
        drive_en = 1'b0;    // released after the last key bit
    endtask

    // first byte of a group is the command
    task automatic decode_byte();
        if (byte_cnt == 0)
        begin
            if (shift == tm1638_pkg::CMD_READ)
                serve_keys();
            else if ((shift & 8'hF0) == tm1638_pkg::CMD_ADDR)
            begin
                addr       = shift[3:0];
                addr_group = 1'b1;
                data_count = 0;
            end
            else if ((shift & 8'hF0) == tm1638_pkg::CMD_DISP)
                ctrl_byte = shift;
        end
        else if (addr_group)
        begin
            ram[addr] = shift;
            addr      = addr + 4'd1;    // auto increment
            data_count++;
        end
    endtask

    initial
    begin
        ram        = '{default: 8'h00};
        ctrl_byte  = 8'h00;
        data_count = 0;
        drive_en   = 1'b0;
        drive_bit  = 1'b1;
        shift      = 8'h00;
        keys_left  = '0;
        addr       = 4'd0;
        addr_group = 1'b0;
        bit_cnt    = 0;
        byte_cnt   = 0;
        forever
        begin
            @(negedge strobe);      // new command group
            bit_cnt    = 0;
            byte_cnt   = 0;
            addr_group = 1'b0;
            while (!strobe)
            begin
                @(posedge sclk or posedge strobe);
                if (!strobe)
                begin
                    shift = {dio, shift[7:1]};
                    bit_cnt++;
                    if (bit_cnt == tm1638_pkg::BYTE_BITS)
                    begin
                        bit_cnt = 0;
                        decode_byte();
                        byte_cnt++;
                    end
                end
            end
            drive_en = 1'b0;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/bash
# build and run the front panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module front_panel_tb \
    -f verilog.f -o front_panel_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/front_panel_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

// File: verilog.f
verilog/tm1638_pkg.sv
verilog/tm1638_serial.sv
verilog/tm1638_keys_display.sv
verilog/hex_seg_encoder.sv
verilog/front_panel_top.sv
bench/tm1638_board_model.sv
bench/front_panel_tb.sv

// File: verilog/front_panel_top.sv
`timescale 1ns/1ps

module front_panel_top
(
    input  logic        clk_5MHz,
    input  logic        n_rst,
    input  logic [31:0] hex_value,
    input  logic [7:0]  dp,
    input  logic [7:0]  leds_green,
    input  logic [7:0]  leds_red,
    input  logic        display_off,
    input  logic [2:0]  display_level,
    output logic [7:0]  keys,
    output logic        tm1638_strobe,
    output logic        tm1638_clk,
    inout  wire         tm1638_data_io
);

    // segment bytes, left to right on the board
    logic [7:0] digit1;
    logic [7:0] digit2;
    logic [7:0] digit3;
    logic [7:0] digit4;
    logic [7:0] digit5;
    logic [7:0] digit6;
    logic [7:0] digit7;
    logic [7:0] digit8;

    hex_seg_encoder u_encoder
    (
        .hex_value (hex_value),
        .dp        (dp),
        .digit1    (digit1),
        .digit2    (digit2),
        .digit3    (digit3),
        .digit4    (digit4),
        .digit5    (digit5),
        .digit6    (digit6),
        .digit7    (digit7),
        .digit8    (digit8)
    );

    tm1638_keys_display u_keys_display
    (
        .clk_5MHz       (clk_5MHz),
        .n_rst          (n_rst),
        .display_off    (display_off),
        .display_level  (display_level),
        .digit1         (digit1),
        .digit2         (digit2),
        .digit3         (digit3),
        .digit4         (digit4),
        .digit5         (digit5),
        .digit6         (digit6),
        .digit7         (digit7),
        .digit8         (digit8),
        .leds_green     (leds_green),
        .leds_red       (leds_red),
        .keys           (keys),
        .tm1638_strobe  (tm1638_strobe),
        .tm1638_clk     (tm1638_clk),
        .tm1638_data_io (tm1638_data_io)
    );

endmodule

// File: verilog/hex_seg_encoder.sv
`timescale 1ns/1ps

module hex_seg_encoder
(
    input  logic [31:0] hex_value,
    input  logic [7:0]  dp,
    output logic [7:0]  digit1,
    output logic [7:0]  digit2,
    output logic [7:0]  digit3,
    output logic [7:0]  digit4,
    output logic [7:0]  digit5,
    output logic [7:0]  digit6,
    output logic [7:0]  digit7,
    output logic [7:0]  digit8
);

    logic [7:0] seg [tm1638_pkg::NUM_DIGITS];

    // segments gfedcba for one hex digit
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0: seg7 = 7'h3F;
            4'h1: seg7 = 7'h06;
            4'h2: seg7 = 7'h5B;
            4'h3: seg7 = 7'h4F;
            4'h4: seg7 = 7'h66;
            4'h5: seg7 = 7'h6D;
            4'h6: seg7 = 7'h7D;
            4'h7: seg7 = 7'h07;
            4'h8: seg7 = 7'h7F;
            4'h9: seg7 = 7'h6F;
            4'hA: seg7 = 7'h77;
            4'hB: seg7 = 7'h7C;   // lower case b
            4'hC: seg7 = 7'h39;
            4'hD: seg7 = 7'h5E;   // lower case d
            4'hE: seg7 = 7'h79;
            default: seg7 = 7'h71;
        endcase
    endfunction

    // leftmost digit takes the top nibble and the top dp bit
    always_comb
    begin
        for (int i = 0; i < tm1638_pkg::NUM_DIGITS; i++)
        begin
            seg[i] = {dp[tm1638_pkg::NUM_DIGITS-1-i],
                      seg7(hex_value[4*(tm1638_pkg::NUM_DIGITS-1-i) +: 4])};
        end
    end

    assign digit1 = seg[0];
    assign digit2 = seg[1];
    assign digit3 = seg[2];
    assign digit4 = seg[3];
    assign digit5 = seg[4];
    assign digit6 = seg[5];
    assign digit7 = seg[6];
    assign digit8 = seg[7];

endmodule

// File: verilog/tm1638_keys_display.sv
`timescale 1ns/1ps

module tm1638_keys_display
(
    input  logic       clk_5MHz,
    input  logic       n_rst,
    input  logic       display_off,
    input  logic [2:0] display_level,
    input  logic [7:0] digit1,
    input  logic [7:0] digit2,
    input  logic [7:0] digit3,
    input  logic [7:0] digit4,
    input  logic [7:0] digit5,
    input  logic [7:0] digit6,
    input  logic [7:0] digit7,
    input  logic [7:0] digit8,
    input  logic [7:0] leds_green,
    input  logic [7:0] leds_red,
    output logic [7:0] keys,
    output logic       tm1638_strobe,
    output logic       tm1638_clk,
    inout  wire        tm1638_data_io
);

    logic [5:0] step;
    logic [5:0] step_next;
    logic       pace;            // steps only on every other cycle

    // serial engine handshake
    logic       latch;
    logic [7:0] tx_byte;
    logic       write_mode;      // also the output enable of the data pin
    logic       busy;
    logic [7:0] rx_byte;
    logic       dio_out;

    logic [7:0] digit [tm1638_pkg::NUM_DIGITS];

    // position inside the key read and the data burst
    logic [5:0] key_off;
    logic [1:0] key_idx;
    logic [5:0] data_off;
    logic [2:0] data_idx;

    assign digit[0] = digit1;
    assign digit[1] = digit2;
    assign digit[2] = digit3;
    assign digit[3] = digit4;
    assign digit[4] = digit5;
    assign digit[5] = digit6;
    assign digit[6] = digit7;
    assign digit[7] = digit8;

    assign key_off  = step - 6'd4;
    assign key_idx  = key_off[2:1];      // steps 4, 6, 8, 10
    assign data_off = step - 6'd17;
    assign data_idx = data_off[3:1];     // digit, then its led pair

    assign step_next = (step == 6'(tm1638_pkg::LAST_STEP)) ? 6'd0 : step + 6'd1;

    // board data pin, released while the keys are read
    assign tm1638_data_io = write_mode ? dio_out : 1'bz;

    tm1638_serial u_serial
    (
        .clk_5MHz   (clk_5MHz),
        .n_rst      (n_rst),
        .latch      (latch),
        .tx_byte    (tx_byte),
        .write_mode (write_mode),
        .busy       (busy),
        .rx_byte    (rx_byte),
        .sclk       (tm1638_clk),
        .dio_in     (tm1638_data_io),
        .dio_out    (dio_out)
    );

    always_ff @(posedge clk_5MHz or posedge n_rst)
    begin
        if (n_rst)
        begin
            step          <= '0;
            pace          <= 1'b0;
            latch         <= 1'b0;
            tx_byte       <= '0;
            write_mode    <= 1'b1;
            tm1638_strobe <= 1'b1;
            keys          <= '0;
        end
        else
        begin
            pace <= ~pace;

            if (pace && !busy)
            begin
                case (step) inside
                    // open a command group
                    6'd1, 6'd12, 6'd15, 6'd34:
                        {tm1638_strobe, write_mode} <= {1'b0, 1'b1};

                    // close a command group, 36 ends the frame
                    6'd11, 6'd14, 6'd33, 6'd36:
                        tm1638_strobe <= 1'b1;

                    6'd2:
                        {latch, tx_byte} <= {1'b1, tm1638_pkg::CMD_READ};

                    6'd3:
                        {latch, write_mode} <= {1'b1, 1'b0};   // first key byte

                    6'd5, 6'd7, 6'd9:
                        latch <= 1'b1;                         // next key byte

                    // key byte k, bit 0 and bit 4
                    6'd4, 6'd6, 6'd8, 6'd10:
                    begin
                        keys[2*tm1638_pkg::KEY_BYTES-1-key_idx] <= rx_byte[0];
                        keys[tm1638_pkg::KEY_BYTES-1-key_idx]   <= rx_byte[4];
                    end

                    6'd13:
                        {latch, tx_byte} <= {1'b1, tm1638_pkg::CMD_WRITE};

                    6'd16:
                        {latch, tx_byte} <= {1'b1, tm1638_pkg::CMD_ADDR};

                    // 16 ram bytes, segments on even addresses
                    [6'd17:6'd32]:
                    begin
                        latch <= 1'b1;
                        if (data_off[0])
                        begin
                            tx_byte <= {6'b0,
                                        leds_red[tm1638_pkg::NUM_DIGITS-1-data_idx],
                                        leds_green[tm1638_pkg::NUM_DIGITS-1-data_idx]};
                        end
                        else
                        begin
                            tx_byte <= digit[data_idx];
                        end
                    end

                    6'd35:
                    begin
                        latch   <= 1'b1;
                        tx_byte <= tm1638_pkg::CMD_DISP | {4'b0, ~display_off, display_level};
                    end

                    default:
                    begin
                    end
                endcase

                step <= step_next;
            end
            else if (busy)
            begin
                latch <= 1'b0;   // engine has taken the byte
            end
        end
    end

endmodule

// File: verilog/tm1638_pkg.sv
package tm1638_pkg;

    // command bytes understood by the TM1638
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h40,    // data write, address auto increment
        CMD_READ  = 8'h42,    // key scan read
        CMD_ADDR  = 8'hC0,    // set address 0
        CMD_DISP  = 8'h80     // display control, on bit and level ored in
    } cmd_e;

    // serial engine states
    // one byte is 8 low/high pairs of the bus clock
    typedef enum logic [1:0] {
        IDLE,
        SCLK_LOW,
        SCLK_HIGH
    } serial_state_e;

    // digit positions on the board
    localparam int NUM_DIGITS = 8;

    // bits per bus transfer
    localparam int BYTE_BITS = 8;

    // key bytes returned per scan
    localparam int KEY_BYTES = 4;

    // step that closes a frame
    // the sequencer wraps back to 0 after it
    localparam int LAST_STEP = 36;

endpackage

// File: verilog/tm1638_serial.sv
`timescale 1ns/1ps

module tm1638_serial
(
    input  logic       clk_5MHz,
    input  logic       n_rst,
    input  logic       latch,
    input  logic [7:0] tx_byte,
    input  logic       write_mode,
    output logic       busy,
    output logic [7:0] rx_byte,
    output logic       sclk,
    input  logic       dio_in,
    output logic       dio_out
);

    tm1638_pkg::serial_state_e state;

    // shared by transmit and receive, lsb leaves or arrives first
    logic [tm1638_pkg::BYTE_BITS-1:0] shift_reg;

    logic [$clog2(tm1638_pkg::BYTE_BITS)-1:0] bit_cnt;

    always_ff @(posedge clk_5MHz or posedge n_rst)
    begin
        if (n_rst)
        begin
            state     <= tm1638_pkg::IDLE;
            sclk      <= 1'b1;           // bus clock idles high
            bit_cnt   <= '0;
            shift_reg <= '1;             // data line idles high
        end
        else
        begin
            case (state)
                tm1638_pkg::IDLE:
                begin
                    if (latch)
                    begin
                        state     <= tm1638_pkg::SCLK_LOW;
                        sclk      <= 1'b0;
                        bit_cnt   <= '0;
                        shift_reg <= tx_byte;    // bit 0 appears with this fall
                    end
                end

                tm1638_pkg::SCLK_LOW:
                begin
                    state <= tm1638_pkg::SCLK_HIGH;
                    sclk  <= 1'b1;
                    // read mode samples the pin as the clock rises
                    if (!write_mode)
                    begin
                        shift_reg <= {dio_in, shift_reg[tm1638_pkg::BYTE_BITS-1:1]};
                    end
                end

                tm1638_pkg::SCLK_HIGH:
                begin
                    if (&bit_cnt)
                    begin
                        state <= tm1638_pkg::IDLE;   // clock stays high
                    end
                    else
                    begin
                        state   <= tm1638_pkg::SCLK_LOW;
                        sclk    <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        // next bit goes out on the falling clock
                        if (write_mode)
                        begin
                            shift_reg <= {1'b1, shift_reg[tm1638_pkg::BYTE_BITS-1:1]};
                        end
                    end
                end

                default:
                begin
                    state <= tm1638_pkg::IDLE;
                    sclk  <= 1'b1;
                end
            endcase
        end
    end

    assign busy    = (state != tm1638_pkg::IDLE);
    assign dio_out = shift_reg[0];

    // complete once busy drops after a read
    assign rx_byte = shift_reg;

endmodule
